// ==== Makefile ====
# Verilator build and run for the memory stage testbench

VERILATOR ?= verilator
TOP       ?= memStageTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, pass only if the pass message appears"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== project.f ====
rtl/memStagePkg.sv
rtl/byteBank.sv
rtl/memAccessUnit.sv
rtl/loadAligner.sv
rtl/redirectUnit.sv
rtl/memStage.sv
verification/clockGen.sv
verification/memStage_assert.sv
verification/memStageTb.sv

// ==== rtl/byteBank.sv ====
`timescale 1ns/1ps

module byteBank #(
    parameter int bankAddrBits = 8
) (
    input  logic                               CLK,
    input  logic [bankAddrBits-1:0]            laneAddr,
    input  logic                               laneWrite,
    input  logic [memStagePkg::byteWidth-1:0]  laneData,
    output logic [memStagePkg::byteWidth-1:0]  laneRead
);

    // One entry per word address
    localparam int depth = 2 ** bankAddrBits;

    logic [memStagePkg::byteWidth-1:0] mem [depth];

    // Write-first single port RAM
    always_ff @(posedge CLK) begin
        if (laneWrite) begin
            mem[laneAddr] <= laneData;
            // New byte shows on the read port at once
            laneRead      <= laneData;
        end else begin
            laneRead      <= mem[laneAddr];
        end
    end

endmodule

// ==== rtl/loadAligner.sv ====
`timescale 1ns/1ps

module loadAligner (
    input  logic                                   CLK,
    input  logic                                   RESET,
    input  logic [memStagePkg::dataWidth-1:0]      laneRead,
    input  logic                                   ctxValid,
    input  logic                                   ctxLoad,
    input  logic                                   ctxRegWrite,
    input  memStagePkg::memOp                      ctxOp,
    input  logic [1:0]                             ctxOffset,
    input  logic [memStagePkg::dataWidth-1:0]      ctxMerge,
    input  logic [memStagePkg::dataWidth-1:0]      ctxAlu,
    input  logic [memStagePkg::regAddrWidth-1:0]   ctxReg,
    output logic                                   wbValid,
    output logic                                   wbRegWrite,
    output logic [memStagePkg::regAddrWidth-1:0]   wbReg,
    output logic [memStagePkg::dataWidth-1:0]      wbData
);
    import memStagePkg::*;

    logic [byteWidth-1:0]   loadByte;
    logic [2*byteWidth-1:0] loadHalf;
    logic [dataWidth-1:0]   leftMask;
    logic [dataWidth-1:0]   rightMask;
    logic [dataWidth-1:0]   loadWord;

    ////////////////////////////////////////////////////////////
    // Lane selection
    ////////////////////////////////////////////////////////////

    // Lane o sits at bits 31-8o down to 24-8o
    assign loadByte = laneRead[dataWidth-1 - byteWidth*ctxOffset -: byteWidth];
    // Low offset bit is ignored for halfwords
    assign loadHalf = ctxOffset[1] ? laneRead[2*byteWidth-1:0]
                                   : laneRead[dataWidth-1:2*byteWidth];

    // LWL keeps register bytes below the loaded ones
    assign leftMask  = {dataWidth{1'b1}} << {ctxOffset, 3'b000};
    // LWR keeps register bytes above the loaded ones
    assign rightMask = {dataWidth{1'b1}} >> {~ctxOffset, 3'b000};

    always_comb begin
        if (!ctxLoad) begin
            // ALU result goes straight to writeback
            loadWord = ctxAlu;
        end else begin
            case (ctxOp)
                opLb:  loadWord = {{(dataWidth-byteWidth){loadByte[byteWidth-1]}}, loadByte};
                opLbu: loadWord = {{(dataWidth-byteWidth){1'b0}}, loadByte};
                opLh:  loadWord = {{(dataWidth-2*byteWidth){loadHalf[2*byteWidth-1]}},
                                   loadHalf};
                opLhu: loadWord = {{(dataWidth-2*byteWidth){1'b0}}, loadHalf};
                opLwl: begin
                    // Lanes o..3 move to the top
                    loadWord = ((laneRead << {ctxOffset, 3'b000}) & leftMask)
                             | (ctxMerge & ~leftMask);
                end
                opLwr: begin
                    // Lanes 0..o move to the bottom
                    loadWord = ((laneRead >> {~ctxOffset, 3'b000}) & rightMask)
                             | (ctxMerge & ~rightMask);
                end
                // LW, LL, LWC1 and anything else take the whole word
                default: loadWord = laneRead;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Writeback register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            wbValid    <= 1'b0;
            wbRegWrite <= 1'b0;
            wbReg      <= '0;
            wbData     <= '0;
        end else begin
            wbValid    <= ctxValid;
            wbRegWrite <= ctxRegWrite;
            wbReg      <= ctxReg;
            wbData     <= loadWord;
        end
    end

endmodule

// ==== rtl/memAccessUnit.sv ====
`timescale 1ns/1ps

module memAccessUnit #(
    parameter int bankAddrBits = 8
) (
    input  logic                                   CLK,
    input  logic                                   RESET,
    input  logic                                   memValid,
    input  logic                                   memRead,
    input  logic                                   memWrite,
    input  logic                                   regWrite,
    input  logic [memStagePkg::dataWidth-1:0]      aluResult,
    input  memStagePkg::memOp                      memOpIn,
    input  logic [memStagePkg::dataWidth-1:0]      regData,
    input  logic [memStagePkg::regAddrWidth-1:0]   destReg,
    output logic [memStagePkg::laneCount-1:0]      laneWrite,
    output logic [memStagePkg::dataWidth-1:0]      laneData,
    output logic [bankAddrBits-1:0]                laneAddr,
    output logic                                   ctxValid,
    output logic                                   ctxLoad,
    output logic                                   ctxRegWrite,
    output memStagePkg::memOp                      ctxOp,
    output logic [1:0]                             ctxOffset,
    output logic [memStagePkg::dataWidth-1:0]      ctxMerge,
    output logic [memStagePkg::dataWidth-1:0]      ctxAlu,
    output logic [memStagePkg::regAddrWidth-1:0]   ctxReg
);
    import memStagePkg::*;

    // Lane masks, bit k is lane k
    localparam logic [laneCount-1:0] oneLane  = 1;
    localparam logic [laneCount-1:0] twoLanes = 3;
    localparam logic [laneCount-1:0] allLanes = '1;

    logic [1:0] offset;
    logic [1:0] halfOffset;
    logic       storeActive;

    // Byte offset inside the word; halfwords ignore bit 0
    assign offset      = aluResult[1:0];
    assign halfOffset  = {offset[1], 1'b0};
    assign storeActive = memValid && memWrite;

    // Word address shared by all banks
    assign laneAddr = aluResult[bankAddrBits+1:2];

    ////////////////////////////////////////////////////////////
    // Store lane split
    ////////////////////////////////////////////////////////////

    always_comb begin
        laneData  = regData;
        laneWrite = '0;
        case (memOpIn)
            opSb: begin
                // Low byte replicated, one lane enabled
                laneData  = {laneCount{regData[byteWidth-1:0]}};
                laneWrite = oneLane << offset;
            end
            opSh: begin
                laneData  = {2{regData[2*byteWidth-1:0]}};
                laneWrite = twoLanes << halfOffset;
            end
            // SC behaves as SW, no reservation kept
            opSw, opSc: begin
                laneWrite = allLanes;
            end
            opSwl: begin
                // MSB lands on lane o, then downward in significance
                laneData  = regData >> {offset, 3'b000};
                laneWrite = allLanes << offset;
            end
            opSwr: begin
                // LSB lands on lane o, lanes below get higher bytes
                laneData  = regData << {~offset, 3'b000};
                laneWrite = allLanes >> ~offset;
            end
            default: begin
                laneWrite = '0;
            end
        endcase
        if (!storeActive) begin
            laneWrite = '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Context for the aligner, one cycle behind the banks
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            ctxValid    <= 1'b0;
            ctxLoad     <= 1'b0;
            ctxRegWrite <= 1'b0;
            ctxOp       <= opNop;
            ctxOffset   <= '0;
            ctxMerge    <= '0;
            ctxAlu      <= '0;
            ctxReg      <= '0;
        end else begin
            ctxValid    <= memValid;
            ctxLoad     <= memValid && memRead;
            ctxRegWrite <= memValid && regWrite;
            ctxOp       <= memOpIn;
            ctxOffset   <= offset;
            // Old destination value for LWL/LWR merge
            ctxMerge    <= regData;
            ctxAlu      <= aluResult;
            ctxReg      <= destReg;
        end
    end

endmodule

// ==== rtl/memStage.sv ====
`timescale 1ns/1ps

module memStage #(
    parameter int bankAddrBits = 8
) (
    input  logic                                   CLK,
    input  logic                                   RESET,
    // From execute
    input  logic                                   memValid,
    input  logic [memStagePkg::dataWidth-1:0]      aluResult,
    input  memStagePkg::memOp                      memOpIn,
    input  logic                                   memRead,
    input  logic                                   memWrite,
    input  logic [memStagePkg::dataWidth-1:0]      regData,
    input  logic [memStagePkg::regAddrWidth-1:0]   destReg,
    input  logic                                   regWrite,
    // Branch resolution
    input  logic                                   branchTaken,
    input  logic [memStagePkg::dataWidth-1:0]      branchTarget,
    input  logic                                   branchPredicted,
    input  logic                                   predictorRequest,
    input  logic [memStagePkg::dataWidth-1:0]      predictorTarget,
    // Writeback
    output logic                                   wbValid,
    output logic [memStagePkg::regAddrWidth-1:0]   wbReg,
    output logic                                   wbRegWrite,
    output logic [memStagePkg::dataWidth-1:0]      wbData,
    // Fetch control
    output logic                                   redirect,
    output logic [memStagePkg::dataWidth-1:0]      redirectPc,
    output logic                                   flush
);
    import memStagePkg::*;

    // Bank side
    logic [laneCount-1:0]    laneWrite;
    logic [dataWidth-1:0]    laneData;
    logic [bankAddrBits-1:0] laneAddr;
    logic [dataWidth-1:0]    laneRead;

    // Load context
    logic                    ctxValid;
    logic                    ctxLoad;
    logic                    ctxRegWrite;
    memOp                    ctxOp;
    logic [1:0]              ctxOffset;
    logic [dataWidth-1:0]    ctxMerge;
    logic [dataWidth-1:0]    ctxAlu;
    logic [regAddrWidth-1:0] ctxReg;

    memAccessUnit #(.bankAddrBits(bankAddrBits)) accessUnit (
        .CLK, .RESET, .memValid, .memRead, .memWrite, .regWrite,
        .aluResult, .memOpIn, .regData, .destReg,
        .laneWrite, .laneData, .laneAddr,
        .ctxValid, .ctxLoad, .ctxRegWrite, .ctxOp,
        .ctxOffset, .ctxMerge, .ctxAlu, .ctxReg
    );

    ////////////////////////////////////////////////////////////
    // Byte banks, lane k holds byte offset k
    ////////////////////////////////////////////////////////////

    for (genvar k = 0; k < laneCount; k++) begin : genBank
        byteBank #(.bankAddrBits(bankAddrBits)) bank (
            .CLK      (CLK),
            .laneAddr (laneAddr),
            .laneWrite(laneWrite[k]),
            .laneData (laneData[dataWidth-1 - byteWidth*k -: byteWidth]),
            .laneRead (laneRead[dataWidth-1 - byteWidth*k -: byteWidth])
        );
    end

    loadAligner aligner (
        .CLK, .RESET, .laneRead,
        .ctxValid, .ctxLoad, .ctxRegWrite, .ctxOp,
        .ctxOffset, .ctxMerge, .ctxAlu, .ctxReg,
        .wbValid, .wbRegWrite, .wbReg, .wbData
    );

    redirectUnit redirector (
        .CLK, .RESET, .branchTaken, .branchPredicted, .predictorRequest,
        .branchTarget, .predictorTarget,
        .redirect, .flush, .redirectPc
    );

endmodule

// ==== rtl/memStagePkg.sv ====
package memStagePkg;

    ////////////////////////////////////////////////////////////
    // Shared widths
    ////////////////////////////////////////////////////////////

    // Datapath word width
    localparam int dataWidth = 32;
    // Byte lanes per word, big-endian order
    localparam int laneCount = 4;
    // Bits per lane
    localparam int byteWidth = 8;
    // Register file index width
    localparam int regAddrWidth = 5;

    ////////////////////////////////////////////////////////////
    // ALU control codes seen by the memory stage
    ////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        // Plain ALU op or bubble
        opNop  = 6'b000000,
        // Loads
        opLb   = 6'b100001,
        opLbu  = 6'b101010,
        opLh   = 6'b101011,
        opLhu  = 6'b101100,
        opLwl  = 6'b101101,
        opLwr  = 6'b101110,
        opLw   = 6'b111101,
        opLl   = 6'b101000,
        opLwc1 = 6'b110101,
        // Stores
        opSb   = 6'b101111,
        opSh   = 6'b110000,
        opSw   = 6'b110001,
        opSc   = 6'b110110,
        opSwl  = 6'b110010,
        opSwr  = 6'b110011
    } memOp;

endpackage

// ==== rtl/redirectUnit.sv ====
`timescale 1ns/1ps

module redirectUnit (
    input  logic                               CLK,
    input  logic                               RESET,
    input  logic                               branchTaken,
    input  logic                               branchPredicted,
    input  logic                               predictorRequest,
    input  logic [memStagePkg::dataWidth-1:0]  branchTarget,
    input  logic [memStagePkg::dataWidth-1:0]  predictorTarget,
    output logic                               redirect,
    output logic                               flush,
    output logic [memStagePkg::dataWidth-1:0]  redirectPc
);

    logic mispredict;

    // Outcome from execute disagrees with the guess
    assign mispredict = branchTaken != branchPredicted;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            redirect   <= 1'b0;
            flush      <= 1'b0;
            redirectPc <= '0;
        end else if (mispredict) begin
            // Resolved outcome wins, younger work is squashed
            redirect   <= branchTaken;
            redirectPc <= branchTarget;
            flush      <= 1'b1;
        end else begin
            redirect <= predictorRequest;
            flush    <= 1'b0;
            // Hold last target when predictor is idle
            if (predictorRequest) begin
                redirectPc <= predictorTarget;
            end
        end
    end

endmodule

// ==== verification/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int halfPeriod  = 10,
    parameter int resetCycles = 16
) (
    output logic CLK,
    output logic RESET
);

    initial begin
        CLK = 1'b0;
        forever #(halfPeriod) CLK = ~CLK;
    end

    // Start high so the async flops see a real falling edge
    initial begin
        RESET = 1'b1;
        #1;
        RESET = 1'b0;
        repeat (resetCycles) @(posedge CLK);
        #2;
        RESET = 1'b1;
    end

endmodule

// ==== verification/memStageTb.sv ====
`timescale 1ns/1ps

module memStageTb;
    import memStagePkg::*;

    localparam int addrBits    = 8;
    localparam int clockPeriod = 20;
    localparam int resetCycles = 16;
    localparam int memBytes    = laneCount << addrBits;
    // Drive cycles per test section
    localparam int fillCycles  = 1 << addrBits;
    localparam int roundIters  = 24;
    localparam int narrowIters = 2 * 4;
    localparam int splitIters  = 2 * 4;
    localparam int aluCycles   = 32;
    localparam int mixCycles   = 160;
    localparam int drainCycles = 4;
    localparam int totalCycles = fillCycles + roundIters * 4 + narrowIters * 10
                               + splitIters * 9 + aluCycles + mixCycles + drainCycles;

    logic                    CLK;
    logic                    RESET;
    logic                    memValid;
    logic                    memRead;
    logic                    memWrite;
    logic                    regWrite;
    logic [dataWidth-1:0]    aluResult;
    logic [dataWidth-1:0]    regData;
    memOp                    memOpIn;
    logic [regAddrWidth-1:0] destReg;
    logic                    branchTaken;
    logic                    branchPredicted;
    logic                    predictorRequest;
    logic [dataWidth-1:0]    branchTarget;
    logic [dataWidth-1:0]    predictorTarget;
    logic                    wbValid;
    logic                    wbRegWrite;
    logic [regAddrWidth-1:0] wbReg;
    logic [dataWidth-1:0]    wbData;
    logic                    redirect;
    logic [dataWidth-1:0]    redirectPc;
    logic                    flush;

    // Big-endian byte image of the banks
    logic [7:0]              shadow [memBytes];
    logic [31:0]             lcgState = 32'h7a17_2863;
    int                      edgeCount = 0;
    int                      errorCount = 0;
    int                      assertFails;
    // Expected writebacks tagged with the edge that loads them
    int                      dueQ [$];
    logic [dataWidth-1:0]    dataQ [$];
    logic [regAddrWidth-1:0] regQ [$];
    logic                    rwQ [$];
    string                   nameQ [$];
    memOp                    opTable [16] = '{opNop, opLb, opLbu, opLh, opLhu, opLwl,
                                              opLwr, opLw, opLl, opLwc1, opSb, opSh,
                                              opSw, opSc, opSwl, opSwr};

    clockGen #(.halfPeriod(clockPeriod / 2), .resetCycles(resetCycles)) clocks (.CLK, .RESET);

    memStage #(.bankAddrBits(addrBits)) DUT (.*);

    // Numerical Recipes LCG
    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic isLoad(memOp op);
        return op inside {opLb, opLbu, opLh, opLhu, opLwl, opLwr, opLw, opLl, opLwc1};
    endfunction

    function automatic logic isStore(memOp op);
        return op inside {opSb, opSh, opSw, opSc, opSwl, opSwr};
    endfunction

    ////////////////////////////////////////////////////////////
    // Shadow memory model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] loadModel(memOp op, logic [31:0] addr, logic [31:0] merge);
        int          base;
        int          o;
        int          j;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] result;
        // Address above the bank depth is dropped
        base   = int'(addr[addrBits+1:2]) * 4;
        o      = int'(addr[1:0]);
        b      = shadow[base + o];
        // Halfwords ignore the low address bit
        h      = {shadow[base + (o & 2)], shadow[base + (o & 2) + 1]};
        result = merge;
        case (op)
            opLb:  result = {{24{b[7]}}, b};
            opLbu: result = {24'h0, b};
            opLh:  result = {{16{h[15]}}, h};
            opLhu: result = {16'h0, h};
            opLwl: begin
                for (j = 0; j <= 3 - o; j++) begin
                    result[31 - 8 * j -: 8] = shadow[base + o + j];
                end
            end
            opLwr: begin
                for (j = 0; j <= o; j++) begin
                    result[8 * j +: 8] = shadow[base + o - j];
                end
            end
            default: result = {shadow[base], shadow[base + 1], shadow[base + 2], shadow[base + 3]};
        endcase
        return result;
    endfunction

    function automatic void storeModel(memOp op, logic [31:0] addr, logic [31:0] data);
        int base;
        int o;
        int j;
        base = int'(addr[addrBits+1:2]) * 4;
        o    = int'(addr[1:0]);
        case (op)
            opSb: shadow[base + o] = data[7:0];
            opSh: begin
                shadow[base + (o & 2)]     = data[15:8];
                shadow[base + (o & 2) + 1] = data[7:0];
            end
            opSw, opSc: begin
                for (j = 0; j < 4; j++) begin
                    shadow[base + j] = data[31 - 8 * j -: 8];
                end
            end
            // SWL fills from the MSB and SWR from the LSB
            opSwl: begin
                for (j = 0; j <= 3 - o; j++) begin
                    shadow[base + o + j] = data[31 - 8 * j -: 8];
                end
            end
            opSwr: begin
                for (j = 0; j <= o; j++) begin
                    shadow[base + o - j] = data[8 * j +: 8];
                end
            end
            default: ;
        endcase
    endfunction

    // One instruction per cycle with branch inputs randomized alongside
    task automatic issue(string name, memOp op, logic [31:0] addr, logic [31:0] data,
                         logic valid);
        logic [31:0] rnd;
        logic [31:0] expected;
        @(posedge CLK);
        #2;
        rnd              = nextRandom();
        branchTaken      = rnd[0];
        branchPredicted  = rnd[1];
        predictorRequest = rnd[2];
        branchTarget     = nextRandom() & ~32'h3;
        predictorTarget  = nextRandom() & ~32'h3;
        memValid         = valid;
        memOpIn          = op;
        memRead          = isLoad(op);
        memWrite         = isStore(op);
        regWrite         = isLoad(op) || (op == opNop && rnd[3]);
        aluResult        = addr;
        regData          = data;
        destReg          = rnd[8:4];
        if (valid) begin
            expected = isLoad(op) ? loadModel(op, addr, data) : addr;
            storeModel(op, addr, data);
            dueQ.push_back(edgeCount + 2);
            dataQ.push_back(expected);
            regQ.push_back(destReg);
            rwQ.push_back(regWrite);
            nameQ.push_back(name);
        end
    endtask

    always @(posedge CLK) begin
        edgeCount = edgeCount + 1;
    end

    ////////////////////////////////////////////////////////////
    // Writeback checker at mid-cycle
    ////////////////////////////////////////////////////////////

    always @(negedge CLK) begin
        if (dueQ.size() > 0 && dueQ[0] == edgeCount) begin
            if (wbValid !== 1'b1) begin
                $display("No writeback for %s at edge %0d", nameQ[0], edgeCount);
                errorCount++;
            end else if (wbData !== dataQ[0]) begin
                $display("FAILED %s: expected %h, actual %h", nameQ[0], dataQ[0], wbData);
                errorCount++;
            end else if ({wbReg, wbRegWrite} !== {regQ[0], rwQ[0]}) begin
                $display("FAILED %s register: expected %h, actual %h", nameQ[0],
                         {regQ[0], rwQ[0]}, {wbReg, wbRegWrite});
                errorCount++;
            end
            dueQ.delete(0);
            dataQ.delete(0);
            regQ.delete(0);
            rwQ.delete(0);
            nameQ.delete(0);
        end else if (wbValid === 1'b1) begin
            $display("Writeback at edge %0d with nothing issued for it", edgeCount);
            errorCount++;
        end
    end

    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] sel;
        int          k;
        int          o;
        memValid = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        aluResult = '0;
        regData = '0;
        memOpIn = opNop;
        destReg = '0;
        branchTaken = 1'b0;
        branchPredicted = 1'b0;
        predictorRequest = 1'b0;
        branchTarget = '0;
        predictorTarget = '0;
        repeat (resetCycles + 1) @(posedge CLK);

        // Every word written once with a pattern from the full word address
        for (k = 0; k < fillCycles; k++) begin
            issue("fill", opSw, 32'(k) << 2, (32'(k) * 32'h0101_0101) ^ 32'hA53C_C35A, 1'b1);
        end

        // Load straight after the store and again after a bubble
        for (k = 0; k < roundIters; k++) begin
            addr = nextRandom() & ~32'h3;
            issue("roundTrip", opSw, addr, nextRandom(), 1'b1);
            issue("roundTrip", opLw, addr, nextRandom(), 1'b1);
            issue("bubble", opNop, 32'h0, 32'h0, 1'b0);
            issue("roundTrip", opLw, addr, 32'h0, 1'b1);
        end

        // Second pass forces the sign bits on
        for (k = 0; k < narrowIters; k++) begin
            o    = k % 4;
            addr = (nextRandom() & ~32'h3) | 32'(o);
            data = (k < 4) ? (nextRandom() & ~32'h8080) : (nextRandom() | 32'h8080);
            issue("storeByte", opSb, addr, data, 1'b1);
            issue("loadByte", opLb, addr, 32'h0, 1'b1);
            issue("loadByteU", opLbu, addr, 32'h0, 1'b1);
            issue("loadHalf", opLh, addr, 32'h0, 1'b1);
            issue("loadHalfU", opLhu, addr, 32'h0, 1'b1);
            issue("storeHalf", opSh, addr, data ^ 32'h0000_7F7F, 1'b1);
            issue("loadHalf", opLh, addr, 32'h0, 1'b1);
            issue("loadHalfU", opLhu, addr, 32'h0, 1'b1);
            issue("loadByte", opLb, addr, 32'h0, 1'b1);
            issue("loadByteU", opLbu, addr, 32'h0, 1'b1);
        end

        // Partial words with a random merge value
        for (k = 0; k < splitIters; k++) begin
            o    = k % 4;
            addr = (nextRandom() & ~32'h3) | 32'(o);
            issue("storeCond", opSc, addr & ~32'h3, nextRandom(), 1'b1);
            issue("storeLeft", opSwl, addr, nextRandom(), 1'b1);
            issue("loadLeft", opLwl, addr, nextRandom(), 1'b1);
            issue("loadRight", opLwr, addr, nextRandom(), 1'b1);
            issue("storeWord", opSw, addr & ~32'h3, nextRandom(), 1'b1);
            issue("storeRight", opSwr, addr, nextRandom(), 1'b1);
            issue("loadRight", opLwr, addr, nextRandom(), 1'b1);
            issue("loadLeft", opLwl, addr, nextRandom(), 1'b1);
            issue("loadLinked", (k < 4) ? opLl : opLwc1, addr & ~32'h3, 32'h0, 1'b1);
        end

        // ALU results with a bubble every fifth cycle
        for (k = 0; k < aluCycles; k++) begin
            issue("aluPass", opNop, nextRandom(), nextRandom(), k % 5 != 4);
        end

        // Only sixteen words so hazards pile up
        // High address bits exercise truncation
        for (k = 0; k < mixCycles; k++) begin
            sel  = nextRandom();
            addr = nextRandom() & 32'hFFFF_FC3F;
            issue("randomMix", opTable[sel[31:28]], addr, nextRandom(), 1'b1);
        end

        for (k = 0; k < drainCycles; k++) begin
            issue("bubble", opNop, 32'h0, 32'h0, 1'b0);
        end

        assertFails = DUT.checks.failCount;
        $display("Writeback check errors: %0d, assertion failures: %0d",
                 errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Budget is the drive cycles plus 40 clock periods
    initial begin : watchdog
        #((totalCycles + 40) * clockPeriod);
        $display("Watchdog expired before the test sequence finished");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== verification/memStage_assert.sv ====
`timescale 1ns/1ps

module memStageAssert (
    input logic                                   CLK,
    input logic                                   RESET,
    input logic                                   memValid,
    input logic                                   memRead,
    input logic                                   memWrite,
    input logic                                   regWrite,
    input logic [memStagePkg::dataWidth-1:0]      aluResult,
    input memStagePkg::memOp                      memOpIn,
    input logic [memStagePkg::regAddrWidth-1:0]   destReg,
    input logic [memStagePkg::laneCount-1:0]      laneWrite,
    input logic                                   wbValid,
    input logic                                   wbRegWrite,
    input logic [memStagePkg::regAddrWidth-1:0]   wbReg,
    input logic [memStagePkg::dataWidth-1:0]      wbData,
    input logic                                   branchTaken,
    input logic                                   branchPredicted,
    input logic                                   predictorRequest,
    input logic [memStagePkg::dataWidth-1:0]      branchTarget,
    input logic [memStagePkg::dataWidth-1:0]      predictorTarget,
    input logic                                   redirect,
    input logic [memStagePkg::dataWidth-1:0]      redirectPc,
    input logic                                   flush
);
    import memStagePkg::*;

    // Read back by the testbench at the end of the run
    int failCount = 0;

    ////////////////////////////////////////////////////////////
    // Reset and lane enables
    ////////////////////////////////////////////////////////////

    // Writeback and fetch control stay quiet while reset is held
    resetQuiet: assert property (@(posedge CLK)
        !RESET |-> !wbValid && !wbRegWrite && !redirect && !flush)
        else begin
            failCount++;
            $error("writeback or fetch control active during reset");
        end

    // SB touches one lane
    byteLane: assert property (@(posedge CLK) disable iff (!RESET)
        memValid && memWrite && memOpIn == opSb |-> $countones(laneWrite) == 1)
        else begin
            failCount++;
            $error("SB did not enable exactly one lane");
        end

    // SH touches two lanes
    halfLanes: assert property (@(posedge CLK) disable iff (!RESET)
        memValid && memWrite && memOpIn == opSh |-> $countones(laneWrite) == 2)
        else begin
            failCount++;
            $error("SH did not enable exactly two lanes");
        end

    // No store, no bank write
    idleLanes: assert property (@(posedge CLK) disable iff (!RESET)
        !(memValid && memWrite) |-> laneWrite == '0)
        else begin
            failCount++;
            $error("bank write without a store");
        end

    ////////////////////////////////////////////////////////////
    // Writeback timing, two edges behind the inputs
    ////////////////////////////////////////////////////////////

    wbTiming: assert property (@(posedge CLK) disable iff (!RESET)
        wbValid == $past(memValid, 2) && wbRegWrite == $past(memValid && regWrite, 2)
        && wbReg == $past(destReg, 2))
        else begin
            failCount++;
            $error("writeback valid, regWrite or register out of step");
        end

    // Non-loads pass the ALU result through
    aluPass: assert property (@(posedge CLK) disable iff (!RESET)
        $past(memValid && !memRead, 2) |-> wbData == $past(aluResult, 2))
        else begin
            failCount++;
            $error("non-load writeback differs from ALU result");
        end

    ////////////////////////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////////////////////////

    mispredictFlush: assert property (@(posedge CLK) disable iff (!RESET)
        branchTaken != branchPredicted |=> flush && redirect == $past(branchTaken)
        && redirectPc == $past(branchTarget))
        else begin
            failCount++;
            $error("mispredict not resolved from branch outcome");
        end

    predictorFollow: assert property (@(posedge CLK) disable iff (!RESET)
        branchTaken == branchPredicted && predictorRequest |=> redirect && !flush
        && redirectPc == $past(predictorTarget))
        else begin
            failCount++;
            $error("predictor request not forwarded");
        end

    quietFetch: assert property (@(posedge CLK) disable iff (!RESET)
        branchTaken == branchPredicted && !predictorRequest |=> !redirect && !flush)
        else begin
            failCount++;
            $error("redirect without cause");
        end

endmodule

bind memStage memStageAssert checks (.*);
